//--- Makefile
TOP := tb_sdram_subsys

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o V$(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- sources.f
+incdir+verilog
verilog/sdram_pkg.sv
verilog/sdram_latency_pipe.sv
verilog/sdram_cmd_decode.sv
verilog/sdram_bank_array.sv
verilog/sdram_ctrl.sv
verilog/sdram_subsys.sv
testbench/sdram_subsys_sva.sv
testbench/tb_sdram_subsys.sv

//--- testbench/sdram_subsys_sva.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_subsys_sva (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 req_strobe,
    input logic                 busy,
    input logic                 rsp_strobe,
    input sdram_pkg::sdr_cmd_e  cmd,
    input sdram_pkg::sdr_bank_t ba
);
    import sdram_pkg::*;

    localparam int BANKS = 1 << `SDR_BANK_BITS;

    // Open banks as seen on the decoded command bus
    logic [BANKS-1:0] open_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            open_q <= '0;
        end else if (cmd == CMD_ACTIVE) begin
            open_q[ba] <= 1'b1;
        end else if (cmd == CMD_PRECHARGE) begin
            open_q[ba] <= 1'b0;
        end
    end

    // Host strobes only while idle
    strobe_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req_strobe |-> !busy)
        else $error("req_strobe while busy is high");

    single_cycle_rsp: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_strobe |=> !rsp_strobe)
        else $error("rsp_strobe high for two cycles in a row");

    active_closed_bank: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd == CMD_ACTIVE) |-> !open_q[ba])
        else $error("ACTIVE to a bank that is already open");

    // Single-word access, row closed right after
    precharge_after_access: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd == CMD_READ || cmd == CMD_WRITE) |=> (cmd == CMD_PRECHARGE))
        else $error("no PRECHARGE in the cycle after READ or WRITE");

endmodule

bind sdram_subsys sdram_subsys_sva sdram_subsys_sva_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_strobe (req_strobe),
    .busy       (busy),
    .rsp_strobe (rsp_strobe),
    .cmd        (cmd),
    .ba         (ba)
);

//--- testbench/tb_sdram_subsys.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module tb_sdram_subsys;
    import sdram_pkg::*;

    // Strobe cycle to rsp_strobe cycle, busy falls in that same cycle
    localparam int READ_LAT   = 1 + `SDR_TRCD + `SDR_CAS_LAT;
    localparam int WAIT_LIMIT = 50;
    localparam int ADDR_BITS  = $bits(host_addr_t);
    localparam int MEM_SIZE   = 1 << ADDR_BITS;
    localparam int LANE       = `SDR_DATA_BITS / 2;

    logic       clk;
    logic       rst_n;
    logic       req_strobe;
    logic       req_write;
    host_addr_t req_addr;
    sdr_word_t  req_wdata;
    sdr_mask_t  req_mask;
    logic       busy;
    logic       rsp_strobe;
    sdr_word_t  rsp_rdata;

    // Reference memory, flat host address
    sdr_word_t  ref_mem   [MEM_SIZE];
    logic       ref_valid [MEM_SIZE];
    host_addr_t written_q [$];

    // Outstanding reads in issue order
    sdr_word_t  exp_q   [$];
    int         issue_q [$];
    string      name_q  [$];

    // Strobe cycle of the access whose busy drop is still pending
    int          busy_start = -1;
    string       busy_name;

    int          cycle_cnt = 0;
    string       test_name;
    logic [15:0] lfsr_state;

    sdram_subsys sdram_subsys_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_strobe (req_strobe),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_mask   (req_mask),
        .busy       (busy),
        .rsp_strobe (rsp_strobe),
        .rsp_rdata  (rsp_rdata)
    );

    always #5 clk = ~clk;

    // Rising edge count, used to time each read
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit, newest bit at the bottom
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Word after a write, masked lanes keep the old byte
    function automatic sdr_word_t merge_word(input sdr_word_t old_word,
                                             input sdr_word_t new_word,
                                             input sdr_mask_t mask);
        sdr_word_t result;
        result = new_word;
        for (int b = 0; b < 2; b++) begin
            if (mask[b]) begin
                result[b*LANE +: LANE] = old_word[b*LANE +: LANE];
            end
        end
        return result;
    endfunction

    function automatic host_addr_t make_addr(input int bank, input int row, input int col);
        host_addr_t a;
        a.bank = sdr_bank_t'(bank);
        a.row  = sdr_row_t'(row);
        a.col  = sdr_col_t'(col);
        return a;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input sdr_word_t expected,
                              input sdr_word_t actual);
        if (actual !== expected) begin
            stop_run($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stop_run($sformatf("FAILED %s latency expected %0d actual %0d",
                               name, expected, actual));
        end
    endtask

    // Sampled mid-cycle, busy is stable there
    task automatic wait_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (busy) begin
            n++;
            if (n > WAIT_LIMIT) begin
                stop_run("timeout while waiting for busy to fall");
            end
            @(negedge clk);
        end
    endtask

    // Until every read has answered and the last busy drop was timed
    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 || busy_start >= 0) begin
            n++;
            if (n > WAIT_LIMIT) begin
                stop_run("timeout while waiting for outstanding accesses");
            end
            @(negedge clk);
        end
    endtask

    // One-cycle strobe as soon as the controller is idle
    task automatic issue(input logic write, input host_addr_t a, input sdr_word_t d,
                         input sdr_mask_t m);
        int start;
        wait_idle();
        @(posedge clk);
        #1;
        start      = cycle_cnt;
        req_strobe = 1'b1;
        req_write  = write;
        req_addr   = a;
        req_wdata  = d;
        req_mask   = m;
        if (write) begin
            ref_mem[a] = merge_word(ref_mem[a], d, m);
            if (!ref_valid[a]) begin
                ref_valid[a] = 1'b1;
                written_q.push_back(a);
            end
        end else begin
            exp_q.push_back(ref_mem[a]);
            issue_q.push_back(start);
            name_q.push_back(test_name);
        end
        @(posedge clk);
        #1;
        req_strobe = 1'b0;
        // Busy is high from here until the access slot passes
        busy_name  = test_name;
        busy_start = start;
    endtask

    task automatic write_word(input host_addr_t a, input sdr_word_t d, input sdr_mask_t m);
        issue(1'b1, a, d, m);
    endtask

    task automatic read_word(input host_addr_t a);
        issue(1'b0, a, '0, '0);
    endtask

    // Every rsp_strobe against the oldest outstanding read, and each busy drop
    initial begin
        int    start;
        string name;
        forever begin
            @(negedge clk);
            if (rsp_strobe) begin
                if (exp_q.size() == 0) begin
                    stop_run("rsp_strobe seen with no read outstanding");
                end else begin
                    start = issue_q.pop_front();
                    name  = name_q.pop_front();
                    check_word(name, exp_q[0], rsp_rdata);
                    check_latency(name, READ_LAT, cycle_cnt - start);
                    void'(exp_q.pop_front());
                end
            end
            // Reads and writes alike free the host port in the response cycle
            if (busy_start >= 0 && !busy) begin
                check_latency({busy_name, " busy"}, READ_LAT, cycle_cnt - busy_start);
                busy_start = -1;
            end
        end
    end

    // Cycle cap on the whole run
    initial begin
        repeat (5000) @(posedge clk);
        stop_run("simulation ran past its cycle limit");
    end

    initial begin
        host_addr_t  a;
        logic [31:0] r;
        sdr_word_t   w;
        sdr_mask_t   m;
        int          idx;
        clk        = 1'b0;
        rst_n      = 1'b0;
        req_strobe = 1'b0;
        req_write  = 1'b0;
        req_addr   = '0;
        req_wdata  = '0;
        req_mask   = '0;
        lfsr_state = 16'd507;
        for (int i = 0; i < MEM_SIZE; i++) begin
            ref_valid[i] = 1'b0;
            ref_mem[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Init sequence, no response expected
        test_name = "reset";
        wait_idle();

        test_name = "write_read";
        a = make_addr(1, 3, 5);
        write_word(a, 16'hA55A, 2'b00);
        read_word(a);
        wait_drain();

        // Low byte masked on the second write
        test_name = "masked_write";
        a = make_addr(2, 9, 14);
        write_word(a, 16'h1234, 2'b00);
        write_word(a, 16'hABCD, 2'b01);
        read_word(a);
        write_word(a, 16'h5E6F, 2'b10);
        read_word(a);
        wait_drain();

        // Same row and column in every bank
        test_name = "bank_isolation";
        for (int b = 0; b < 4; b++) begin
            write_word(make_addr(b, 7, 9), sdr_word_t'(16'h1C30 + b * 16'h0101), 2'b00);
        end
        for (int b = 0; b < 4; b++) begin
            read_word(make_addr(b, 7, 9));
        end
        wait_drain();

        test_name = "random_mix";
        for (int n = 0; n < 40; n++) begin
            take_bits(1, r);
            if (r[0] || written_q.size() == 0) begin
                take_bits(ADDR_BITS, r);
                a = r[ADDR_BITS-1:0];
                take_bits(`SDR_DATA_BITS, r);
                w = r[`SDR_DATA_BITS-1:0];
                take_bits(2, r);
                m = r[1:0];
                // Fresh address gets the whole word
                if (!ref_valid[a]) begin
                    m = 2'b00;
                end
                write_word(a, w, m);
            end else begin
                take_bits(6, r);
                idx = int'(r[5:0]) % written_q.size();
                read_word(written_q[idx]);
            end
        end
        wait_drain();
        wait_idle();

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

//--- verilog/sdram_bank_array.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_bank_array (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sdram_pkg::sdr_cmd_e  cmd,
    input  sdram_pkg::sdr_bank_t ba,
    input  sdram_pkg::sdr_row_t  addr,
    input  sdram_pkg::sdr_word_t wdata,
    input  sdram_pkg::sdr_mask_t dqm,
    output logic                 fetch_strobe,
    output sdram_pkg::sdr_word_t fetch_data
);
    import sdram_pkg::*;

    localparam int BANKS = 1 << `SDR_BANK_BITS;
    localparam int ROWS  = 1 << `SDR_ROW_BITS;
    localparam int COLS  = 1 << `SDR_COL_BITS;
    localparam int LANE  = `SDR_DATA_BITS / 2;

    // Storage, bank by row by column
    sdr_word_t        mem [BANKS][ROWS][COLS];

    logic             mode_loaded;
    logic [BANKS-1:0] bank_open;
    sdr_row_t         open_row [BANKS];
    sdr_col_t         col;
    logic             access_ok;

    // Column sits in the low bits of the address pins
    assign col = sdr_col_t'(addr);

    // Access needs a loaded mode and an open row in the bank
    assign access_ok = mode_loaded && bank_open[ba];

    // Mode flag, bank state and read strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode_loaded  <= 1'b0;
            bank_open    <= '0;
            fetch_strobe <= 1'b0;
        end else begin
            fetch_strobe <= (cmd == CMD_READ) && access_ok;
            case (cmd)
                CMD_LOAD_MODE: begin
                    mode_loaded <= 1'b1;
                end
                CMD_ACTIVE: begin
                    if (mode_loaded) begin
                        bank_open[ba] <= 1'b1;
                    end
                end
                CMD_PRECHARGE: begin
                    // Single bank only
                    bank_open[ba] <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // Row latched on ACTIVE
    always_ff @(posedge clk) begin
        if (cmd == CMD_ACTIVE && mode_loaded) begin
            open_row[ba] <= addr;
        end
    end

    // Masked byte writes into the open row
    always_ff @(posedge clk) begin
        if (cmd == CMD_WRITE && access_ok) begin
            for (int b = 0; b < 2; b++) begin
                if (!dqm[b]) begin
                    mem[ba][open_row[ba]][col][b*LANE +: LANE] <= wdata[b*LANE +: LANE];
                end
            end
        end
    end

    // Read word registered one cycle after READ
    always_ff @(posedge clk) begin
        if (cmd == CMD_READ && access_ok) begin
            fetch_data <= mem[ba][open_row[ba]][col];
        end
    end

endmodule

//--- verilog/sdram_cmd_decode.sv
`timescale 1ns/1ps

module sdram_cmd_decode (
    input  logic                cs_n,
    input  logic                ras_n,
    input  logic                cas_n,
    input  logic                we_n,
    output sdram_pkg::sdr_cmd_e cmd
);
    import sdram_pkg::*;

    // JEDEC truth table on the active-low strobes
    always_comb begin
        if (cs_n) begin
            // Deselected, pins are don't care
            cmd = CMD_INHIBIT;
        end else begin
            case ({ras_n, cas_n, we_n})
                3'b111: cmd = CMD_NOP;
                3'b011: cmd = CMD_ACTIVE;
                3'b101: cmd = CMD_READ;
                3'b100: cmd = CMD_WRITE;
                3'b010: cmd = CMD_PRECHARGE;
                3'b000: cmd = CMD_LOAD_MODE;
                // Auto refresh and burst terminate have no effect here
                3'b001: cmd = CMD_NOP;
                default: cmd = CMD_NOP;
            endcase
        end
    end

endmodule

//--- verilog/sdram_ctrl.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_strobe,
    input  logic                  req_write,
    input  sdram_pkg::host_addr_t req_addr,
    input  sdram_pkg::sdr_word_t  req_wdata,
    input  sdram_pkg::sdr_mask_t  req_mask,
    input  logic                  rd_strobe,
    input  sdram_pkg::sdr_word_t  rd_data,
    output logic                  busy,
    output logic                  rsp_strobe,
    output sdram_pkg::sdr_word_t  rsp_rdata,
    output logic                  cs_n,
    output logic                  ras_n,
    output logic                  cas_n,
    output logic                  we_n,
    output sdram_pkg::sdr_bank_t  ba,
    output sdram_pkg::sdr_row_t   addr,
    output sdram_pkg::sdr_word_t  wdata,
    output sdram_pkg::sdr_mask_t  dqm
);
    import sdram_pkg::*;

    // Pin patterns as {cs_n, ras_n, cas_n, we_n}
    localparam logic [3:0] PIN_NOP  = 4'b0111;
    localparam logic [3:0] PIN_ACT  = 4'b0011;
    localparam logic [3:0] PIN_RD   = 4'b0101;
    localparam logic [3:0] PIN_WR   = 4'b0100;
    localparam logic [3:0] PIN_PRE  = 4'b0010;
    localparam logic [3:0] PIN_LMR  = 4'b0000;

    localparam int RCD_BITS = $clog2(`SDR_TRCD + 1);

    typedef enum logic [2:0] {
        ST_INIT,
        ST_LOAD,
        ST_IDLE,
        ST_RCD,
        ST_PRE,
        ST_WAIT
    } state_e;

    state_e              state_q;
    logic [3:0]          pins_q;
    logic [RCD_BITS-1:0] rcd_cnt;
    logic                write_q;
    sdr_col_t            col_q;
    logic                access_issue;
    logic                slot_done;
    logic                slot_read;

    // Last ACTIVE-to-access gap cycle, access command goes out next
    assign access_issue = (state_q == ST_RCD) && (rcd_cnt == RCD_BITS'(`SDR_TRCD - 1));

    assign {cs_n, ras_n, cas_n, we_n} = pins_q;

    // Busy drops in the cycle the access slot leaves the marker pipe
    assign busy = (state_q != ST_IDLE) && !slot_done;

    // Only a read slot forwards the device word
    assign rsp_strobe = rd_strobe && slot_done && slot_read;
    assign rsp_rdata  = rd_data;

    // Init then access sequencer, pins registered
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_INIT;
            pins_q  <= PIN_NOP;
            rcd_cnt <= '0;
        end else begin
            // NOP unless a state below says otherwise
            pins_q <= PIN_NOP;
            case (state_q)
                ST_INIT: begin
                    pins_q  <= PIN_LMR;
                    state_q <= ST_LOAD;
                end
                ST_LOAD: begin
                    state_q <= ST_IDLE;
                end
                ST_IDLE: begin
                    if (req_strobe) begin
                        pins_q  <= PIN_ACT;
                        rcd_cnt <= '0;
                        state_q <= ST_RCD;
                    end
                end
                ST_RCD: begin
                    if (access_issue) begin
                        pins_q  <= write_q ? PIN_WR : PIN_RD;
                        state_q <= ST_PRE;
                    end else begin
                        rcd_cnt <= rcd_cnt + 1'b1;
                    end
                end
                ST_PRE: begin
                    // Close the row right after the single-word access
                    pins_q  <= PIN_PRE;
                    state_q <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (slot_done) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_INIT;
                end
            endcase
        end
    end

    // Request latch and address/data pins
    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req_strobe) begin
            write_q <= req_write;
            col_q   <= req_addr.col;
            ba      <= req_addr.bank;
            addr    <= req_addr.row;
            // Held on the pins until the WRITE goes out
            wdata   <= req_wdata;
            dqm     <= req_mask;
        end else if (access_issue) begin
            addr <= sdr_row_t'(col_q);
        end else if (state_q == ST_INIT) begin
            // Mode word with burst length one
            addr <= '0;
        end
    end

    // Marks each access slot, set for reads
    sdram_latency_pipe #(
        .DEPTH     (`SDR_CAS_LAT + 1),
        .payload_t (logic)
    ) marker_pipe_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_strobe   (access_issue),
        .in_payload  (!write_q),
        .out_strobe  (slot_done),
        .out_payload (slot_read)
    );

endmodule

//--- verilog/sdram_latency_pipe.sv
`timescale 1ns/1ps

module sdram_latency_pipe #(
    parameter int  DEPTH     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_strobe,
    input  payload_t in_payload,
    output logic     out_strobe,
    output payload_t out_payload
);

    logic     strobe_q  [DEPTH];
    payload_t payload_q [DEPTH];

    // Strobe chain, cleared on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                strobe_q[i] <= 1'b0;
            end
        end else begin
            strobe_q[0] <= in_strobe;
            for (int i = 1; i < DEPTH; i++) begin
                strobe_q[i] <= strobe_q[i-1];
            end
        end
    end

    // Payload moves every cycle, meaningful only beside its strobe
    always_ff @(posedge clk) begin
        payload_q[0] <= in_payload;
        for (int i = 1; i < DEPTH; i++) begin
            payload_q[i] <= payload_q[i-1];
        end
    end

    assign out_strobe  = strobe_q[DEPTH-1];
    assign out_payload = payload_q[DEPTH-1];

endmodule

//--- verilog/sdram_pkg.sv
`include "sdram_settings.svh"

package sdram_pkg;

    // Decoded command on the device pins
    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_ACTIVE,
        CMD_READ,
        CMD_WRITE,
        CMD_PRECHARGE,
        CMD_LOAD_MODE,
        CMD_INHIBIT
    } sdr_cmd_e;

    typedef logic [`SDR_DATA_BITS-1:0] sdr_word_t;

    // Active high, one bit per byte lane
    typedef logic [1:0] sdr_mask_t;

    typedef logic [`SDR_BANK_BITS-1:0] sdr_bank_t;
    typedef logic [`SDR_ROW_BITS-1:0] sdr_row_t;
    typedef logic [`SDR_COL_BITS-1:0] sdr_col_t;

    // Host address, bank in the top bits and column at the bottom
    typedef struct packed {
        sdr_bank_t bank;
        sdr_row_t  row;
        sdr_col_t  col;
    } host_addr_t;

endpackage

//--- verilog/sdram_settings.svh
`ifndef SDRAM_SETTINGS_SVH
`define SDRAM_SETTINGS_SVH

// Device geometry, shrunk so the array fits in simulation
`define SDR_BANK_BITS 2
`define SDR_ROW_BITS 4
`define SDR_COL_BITS 4

// Word width, split into two byte lanes under dqm
`define SDR_DATA_BITS 16

// NOP gap between ACTIVE and the access command
`define SDR_TRCD 2

// READ command to read word at the host
// Fixed at build time, LOAD_MODE does not change it
`define SDR_CAS_LAT 2

`endif

//--- verilog/sdram_subsys.sv
`timescale 1ns/1ps
`include "sdram_settings.svh"

module sdram_subsys (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_strobe,
    input  logic                  req_write,
    input  sdram_pkg::host_addr_t req_addr,
    input  sdram_pkg::sdr_word_t  req_wdata,
    input  sdram_pkg::sdr_mask_t  req_mask,
    output logic                  busy,
    output logic                  rsp_strobe,
    output sdram_pkg::sdr_word_t  rsp_rdata
);
    import sdram_pkg::*;

    // Command bus between controller and device
    logic      cs_n;
    logic      ras_n;
    logic      cas_n;
    logic      we_n;
    sdr_bank_t ba;
    sdr_row_t  addr;
    sdr_word_t wdata;
    sdr_mask_t dqm;

    // Device internals
    sdr_cmd_e  cmd;
    logic      fetch_strobe;
    sdr_word_t fetch_data;
    logic      rd_strobe;
    sdr_word_t rd_data;

    sdram_ctrl sdram_ctrl_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_strobe (req_strobe),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_mask   (req_mask),
        .rd_strobe  (rd_strobe),
        .rd_data    (rd_data),
        .busy       (busy),
        .rsp_strobe (rsp_strobe),
        .rsp_rdata  (rsp_rdata),
        .cs_n       (cs_n),
        .ras_n      (ras_n),
        .cas_n      (cas_n),
        .we_n       (we_n),
        .ba         (ba),
        .addr       (addr),
        .wdata      (wdata),
        .dqm        (dqm)
    );

    // Device model: decode, array, then CAS latency
    sdram_cmd_decode sdram_cmd_decode_inst (
        .cs_n  (cs_n),
        .ras_n (ras_n),
        .cas_n (cas_n),
        .we_n  (we_n),
        .cmd   (cmd)
    );

    sdram_bank_array sdram_bank_array_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .ba           (ba),
        .addr         (addr),
        .wdata        (wdata),
        .dqm          (dqm),
        .fetch_strobe (fetch_strobe),
        .fetch_data   (fetch_data)
    );

    // Array fetch already spends one cycle of the latency
    sdram_latency_pipe #(
        .DEPTH     (`SDR_CAS_LAT - 1),
        .payload_t (sdr_word_t)
    ) read_pipe_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_strobe   (fetch_strobe),
        .in_payload  (fetch_data),
        .out_strobe  (rd_strobe),
        .out_payload (rd_data)
    );

endmodule
